//--- cpu_core.f
+incdir+include
hw/isa_pkg.sv
hw/pipe_pkg.sv
hw/barrel_shifter.sv
hw/decode_stage.sv
hw/operand_stage.sv
hw/execute_stage.sv
hw/cpu_core.sv
testbench/cpu_ref_model.sv
testbench/tb_clock.sv
testbench/cpu_core_tb.sv

//--- Bender.yml
package:
  name: cpu_core

export_include_dirs:
  - include

sources:
  - include_dirs:
      - include
    files:
      - hw/isa_pkg.sv
      - hw/pipe_pkg.sv
      - hw/barrel_shifter.sv
      - hw/decode_stage.sv
      - hw/operand_stage.sv
      - hw/execute_stage.sv
      - hw/cpu_core.sv
  - target: test
    include_dirs:
      - include
    files:
      - testbench/cpu_ref_model.sv
      - testbench/tb_clock.sv
      - testbench/cpu_core_tb.sv

//--- testbench/cpu_core_tb.sv
`timescale 1ns/1ps
`default_nettype none

`include "cpu_macros.svh"

module cpu_core_tb import isa_pkg::*, pipe_pkg::*, cpu_ref_model::*; ();

  localparam int N_RANDOM = 600;

  logic         clk;
  logic         i_reset;
  logic         i_valid;
  instr_t       i_instr;
  retire_t      o_retire;
  flags_t       o_flags;

  integer       seed;
  model_state_t model;
  retire_t      expected_q[$];
  string        expected_name[$];
  logic [31:0]  stim_word[$];
  logic         stim_valid[$];
  string        stim_name[$];
  int           n_instr;
  int           n_idle;
  int           cycle_limit;
  int           cycles;
  int           retired;

  tb_clock clock_inst (
    .o_clk (clk)
  );

  cpu_core cpu_core_inst (
    .clk      (clk),
    .i_reset  (i_reset),
    .i_valid  (i_valid),
    .i_instr  (i_instr),
    .o_retire (o_retire),
    .o_flags  (o_flags)
  );

  task automatic check_equal(input string name, input logic [31:0] expected,
                             input logic [31:0] actual);
    if (actual !== expected) begin
      $display("[FAIL] %s expected %h actual %h", name, expected, actual);
      $display("TESTBENCH FAILED");
      $fatal(1, "value mismatch in %s", name);
    end
  endtask

  function automatic logic [31:0] make_dp(logic [3:0] cond, logic imm, alu_op_e op,
                                          logic s, logic [3:0] rn, logic [3:0] rd,
                                          logic [11:0] op2);
    return {cond, 2'b00, imm, op, s, rn, rd, op2};
  endfunction

  // kind 0 register form, 1 immediate, 2 dependent on prev_rd, 3 bubble
  function automatic logic [31:0] random_word(int kind, logic [3:0] prev_rd);
    logic [31:0] r;
    logic [31:0] w;
    r = $random(seed);
    w = $random(seed);
    w[31:28] = (r[0] || kind == 2) ? 4'hE : r[4:1];
    w[27:26] = 2'b00;
    case (kind)
      0, 2: begin
        w[25] = 1'b0;
        w[4]  = 1'b0;
        // shift amount 0 selects RRX and shift by 32
        if (r[12:10] == 3'd0) begin
          w[11:7] = 5'd0;
        end
        if (kind == 2) begin
          if (r[5] || r[6]) begin
            w[19:16] = prev_rd;
          end
          if (!r[5] || r[6]) begin
            w[3:0] = prev_rd;
          end
        end
      end
      1: w[25] = 1'b1;
      default: begin
        case (r[6:5])
          2'd0: w[27:26] = (r[8:7] == 2'b00) ? 2'b01 : r[8:7];
          2'd1: begin
            w[24:23] = 2'b10;
            w[20]    = 1'b0;
          end
          default: begin
            w[25] = 1'b0;
            w[4]  = 1'b1;
          end
        endcase
      end
    endcase
    // compares need S, or they become PSR transfers
    if (kind != 3 && w[24:23] == 2'b10) begin
      w[20] = 1'b1;
    end
    return w;
  endfunction

  task automatic add_slot(input logic valid, input logic [31:0] word, input string name);
    stim_valid.push_back(valid);
    stim_word.push_back(word);
    stim_name.push_back(name);
    if (valid) begin
      n_instr++;
    end else begin
      n_idle++;
    end
  endtask

  task automatic build_stimulus();
    logic [31:0] r;
    logic [31:0] word;
    logic [3:0]  prev_rd;
    int          kind;
    string       name;
    prev_rd = 4'd0;
    // every register must read zero straight after reset
    for (int i = 0; i < `CPU_NREGS; i++) begin
      add_slot(1'b1, make_dp(4'hE, 1'b0, OP_ORR, 1'b0, 4'(i), 4'(i), {8'b0, 4'(i)}),
               "reset_readout");
    end
    for (int i = 0; i < `CPU_NREGS; i++) begin
      r = $random(seed);
      add_slot(1'b1, make_dp(4'hE, 1'b1, OP_MOV, 1'b0, 4'h0, 4'(i), r[11:0]), "load");
      add_slot(1'b1, make_dp(4'hE, 1'b1, OP_EOR, 1'b1, 4'(i), 4'(i), r[27:16]), "load");
    end
    for (int k = 0; k < N_RANDOM; k++) begin
      r    = $random(seed);
      kind = (r[2:0] < 3) ? 0 : (r[2:0] < 5) ? 1 : (r[2:0] < 7) ? 2 : 3;
      case (kind)
        0: name = "random_reg";
        1: name = "random_imm";
        2: name = "dependency";
        default: name = "bubble";
      endcase
      // dependent words follow their producer with no gap
      if (kind != 2 && ((r >> 8) % 3 != 0)) begin
        add_slot(1'b0, $random(seed), "idle");
      end
      word = random_word(kind, prev_rd);
      add_slot(1'b1, word, name);
      prev_rd = word[15:12];
    end
    for (int i = 0; i < `CPU_NREGS; i++) begin
      add_slot(1'b1, make_dp(4'hE, 1'b0, OP_MOV, 1'b1, 4'h0, 4'(i), {8'b0, 4'(i)}),
               "final_readout");
    end
  endtask

  task automatic check_retire();
    retire_t exp;
    string   base;
    if (expected_q.size() == 0) begin
      $display("retire output went valid with no instruction in flight");
      $display("TESTBENCH FAILED");
      $fatal(1, "unexpected retire");
    end else begin
      exp  = expected_q.pop_front();
      base = $sformatf("%s #%0d", expected_name.pop_front(), retired);
      check_equal({base, " valid"}, exp.valid, o_retire.valid);
      check_equal({base, " written"}, exp.written, o_retire.written);
      check_equal({base, " rd"}, exp.rd, o_retire.rd);
      check_equal({base, " data"}, exp.data, o_retire.data);
      check_equal({base, " flags"}, exp.flags, o_retire.flags);
      check_equal({base, " o_flags"}, exp.flags, o_flags);
      retired++;
    end
  endtask

  // outputs settle after the rising edge
  always @(negedge clk) begin
    if (!i_reset && o_retire.valid !== 1'b0) begin
      check_retire();
    end
  end

  always @(posedge clk) begin
    if (!i_reset) begin
      cycles++;
      if (cycles > cycle_limit) begin
        $display("timeout after %0d cycles with %0d retires outstanding", cycles,
                 expected_q.size());
        $display("TESTBENCH FAILED");
        $fatal(1, "timeout");
      end
    end
  end

  initial begin
    seed    = 54551;
    i_reset = 1'b1;
    i_valid = 1'b0;
    i_instr = '0;
    model   = '0;
    n_instr = 0;
    n_idle  = 0;
    cycles  = 0;
    retired = 0;
    build_stimulus();
    cycle_limit = n_instr + n_idle + `CPU_LATENCY + 10;
    repeat (3) @(posedge clk);
    #1;
    i_reset = 1'b0;
    for (int k = 0; k < stim_word.size(); k++) begin
      i_valid = stim_valid[k];
      i_instr = instr_t'(stim_word[k]);
      if (stim_valid[k]) begin
        expected_q.push_back(execute_instr(model, stim_word[k]));
        expected_name.push_back(stim_name[k]);
      end
      @(posedge clk);
      #1;
    end
    i_valid = 1'b0;
    wait (expected_q.size() == 0);
    repeat (3) @(posedge clk);
    check_equal("final flags", model.flags, o_flags);
    $display("TESTBENCH PASSED");
    $finish;
  end

endmodule

`default_nettype wire

//--- testbench/tb_clock.sv
`timescale 1ns/1ps
`default_nettype none

module tb_clock #(
  parameter int PERIOD_NS = 10
) (
  output logic o_clk
);

  initial begin
    o_clk = 1'b0;
    forever #(PERIOD_NS / 2) o_clk = ~o_clk;
  end

endmodule

`default_nettype wire

//--- testbench/cpu_ref_model.sv
`default_nettype none

`include "cpu_macros.svh"

package cpu_ref_model;
  import isa_pkg::*;
  import pipe_pkg::*;

  typedef struct packed {
    logic [`CPU_NREGS-1:0][`CPU_XLEN-1:0] regs;
    flags_t                               flags;
  } model_state_t;

  // standard ARM condition table, code 15 never passes
  function automatic logic cond_ok(logic [3:0] cond, flags_t f);
    case (cond)
      4'd0: return f.z;
      4'd1: return !f.z;
      4'd2: return f.c;
      4'd3: return !f.c;
      4'd4: return f.n;
      4'd5: return !f.n;
      4'd6: return f.v;
      4'd7: return !f.v;
      4'd8: return f.c && !f.z;
      4'd9: return !f.c || f.z;
      4'd10: return f.n == f.v;
      4'd11: return f.n != f.v;
      4'd12: return !f.z && (f.n == f.v);
      4'd13: return f.z || (f.n != f.v);
      4'd14: return 1'b1;
      default: return 1'b0;
    endcase
  endfunction

  // operand 2 from the instruction word, carry is the last bit shifted out
  function automatic logic [31:0] operand2(logic [31:0] word, logic [31:0] rm_val,
                                           logic cin, output logic cout);
    int          amt;
    logic [31:0] imm;
    logic [31:0] val;
    if (word[25]) begin
      amt  = 2 * int'(word[11:8]);
      imm  = {24'b0, word[7:0]};
      val  = (amt == 0) ? imm : ((imm >> amt) | (imm << (32 - amt)));
      cout = (amt == 0) ? cin : val[31];
      return val;
    end
    amt = int'(word[11:7]);
    case (word[6:5])
      2'd0: begin
        val  = rm_val << amt;
        cout = (amt == 0) ? cin : rm_val[32 - amt];
      end
      2'd1: begin
        amt  = (amt == 0) ? 32 : amt;
        val  = rm_val >> amt;
        cout = rm_val[amt - 1];
      end
      2'd2: begin
        amt  = (amt == 0) ? 32 : amt;
        val  = (rm_val >> amt) | (rm_val[31] ? ~(32'hffff_ffff >> amt) : 32'h0);
        cout = rm_val[amt - 1];
      end
      default: begin
        if (amt == 0) begin
          // RRX
          val  = {cin, rm_val[31:1]};
          cout = rm_val[0];
        end else begin
          val  = (rm_val >> amt) | (rm_val << (32 - amt));
          cout = rm_val[amt - 1];
        end
      end
    endcase
    return val;
  endfunction

  // exact wide arithmetic, carry is not-borrow when subtracting
  function automatic logic [31:0] add_sub(logic [31:0] x, logic [31:0] y, logic cin,
                                          logic sub, output logic cout, output logic vout);
    longint ur;
    longint sr;
    if (sub) begin
      ur   = longint'(x) - longint'(y) - (cin ? 0 : 1);
      sr   = longint'($signed(x)) - longint'($signed(y)) - (cin ? 0 : 1);
      cout = !ur[63];
    end else begin
      ur   = longint'(x) + longint'(y) + (cin ? 1 : 0);
      sr   = longint'($signed(x)) + longint'($signed(y)) + (cin ? 1 : 0);
      cout = ur[32];
    end
    vout = (sr != longint'($signed(sr[31:0])));
    return ur[31:0];
  endfunction

  function automatic retire_t execute_instr(inout model_state_t st, input logic [31:0] word);
    retire_t     ret;
    logic [3:0]  op;
    logic [31:0] a;
    logic [31:0] b;
    logic [31:0] res;
    logic        sh_c;
    logic        ar_c;
    logic        ar_v;
    logic        arith;
    logic        is_dp;
    op    = word[24:21];
    is_dp = (word[27:26] == 2'b00) && !((op[3:2] == 2'b10) && !word[20]) &&
            !(!word[25] && word[4]);
    ret.valid   = 1'b1;
    ret.written = 1'b0;
    ret.rd      = word[15:12];
    ret.data    = '0;
    ret.flags   = st.flags;
    if (!is_dp || !cond_ok(word[31:28], st.flags)) begin
      return ret;
    end
    a     = st.regs[word[19:16]];
    b     = operand2(word, st.regs[word[3:0]], st.flags.c, sh_c);
    ar_c  = 1'b0;
    ar_v  = 1'b0;
    arith = 1'b0;
    case (op)
      OP_AND, OP_TST: res = a & b;
      OP_EOR, OP_TEQ: res = a ^ b;
      OP_ORR: res = a | b;
      OP_MOV: res = b;
      OP_BIC: res = a & ~b;
      OP_MVN: res = ~b;
      default: begin
        arith = 1'b1;
        case (op)
          OP_SUB, OP_CMP: res = add_sub(a, b, 1'b1, 1'b1, ar_c, ar_v);
          OP_RSB: res = add_sub(b, a, 1'b1, 1'b1, ar_c, ar_v);
          OP_ADD, OP_CMN: res = add_sub(a, b, 1'b0, 1'b0, ar_c, ar_v);
          OP_ADC: res = add_sub(a, b, st.flags.c, 1'b0, ar_c, ar_v);
          OP_SBC: res = add_sub(a, b, st.flags.c, 1'b1, ar_c, ar_v);
          default: res = add_sub(b, a, st.flags.c, 1'b1, ar_c, ar_v);
        endcase
      end
    endcase
    if (op[3:2] != 2'b10) begin
      st.regs[word[15:12]] = res;
      ret.written          = 1'b1;
      ret.data             = res;
    end
    if (word[20]) begin
      st.flags.n = res[31];
      st.flags.z = (res == 32'h0);
      st.flags.c = arith ? ar_c : sh_c;
      if (arith) begin
        st.flags.v = ar_v;
      end
    end
    ret.flags = st.flags;
    return ret;
  endfunction

endpackage

`default_nettype wire

//--- hw/cpu_core.sv
`timescale 1ns/1ps
`default_nettype none

module cpu_core import isa_pkg::*, pipe_pkg::*; (
  input  logic    clk,
  input  logic    i_reset,
  input  logic    i_valid,
  input  instr_t  i_instr,
  output retire_t o_retire,
  output flags_t  o_flags
);

  decoded_t  dec;
  operands_t ops;
  wb_t       wb;

  decode_stage decode_inst (
    .clk     (clk),
    .i_reset (i_reset),
    .i_valid (i_valid),
    .i_instr (i_instr),
    .o_dec   (dec)
  );

  // wb feeds both the register write and the bypass
  operand_stage operand_inst (
    .clk     (clk),
    .i_reset (i_reset),
    .i_dec   (dec),
    .i_wb    (wb),
    .o_ops   (ops)
  );

  execute_stage execute_inst (
    .clk      (clk),
    .i_reset  (i_reset),
    .i_ops    (ops),
    .o_wb     (wb),
    .o_retire (o_retire),
    .o_flags  (o_flags)
  );

endmodule

`default_nettype wire

//--- hw/execute_stage.sv
`timescale 1ns/1ps
`default_nettype none

`include "cpu_macros.svh"

module execute_stage import isa_pkg::*, pipe_pkg::*; (
  input  logic      clk,
  input  logic      i_reset,
  input  operands_t i_ops,
  output wb_t       o_wb,
  output retire_t   o_retire,
  output flags_t    o_flags
);

  flags_t               flags_q;
  flags_t               flags_d;
  retire_t              retire_q;
  logic [`CPU_XLEN-1:0] sh_in;
  logic [`CPU_XLEN-1:0] sh_out;
  logic                 sh_carry;
  logic [`CPU_XLEN-1:0] add_x;
  logic [`CPU_XLEN-1:0] add_y;
  logic                 add_cin;
  logic [`CPU_XLEN:0]   sum;
  logic                 add_v;
  logic                 is_arith;
  logic [`CPU_XLEN-1:0] result;
  logic                 executes;
  logic                 writes;

  function automatic logic cond_pass(cond_e cond, flags_t f);
    case (cond)
      COND_EQ: return f.z;
      COND_NE: return !f.z;
      COND_CS: return f.c;
      COND_CC: return !f.c;
      COND_MI: return f.n;
      COND_PL: return !f.n;
      COND_VS: return f.v;
      COND_VC: return !f.v;
      COND_HI: return f.c && !f.z;
      COND_LS: return !f.c || f.z;
      COND_GE: return f.n == f.v;
      COND_LT: return f.n != f.v;
      COND_GT: return !f.z && (f.n == f.v);
      COND_LE: return f.z || (f.n != f.v);
      COND_AL: return 1'b1;
      default: return 1'b0;
    endcase
  endfunction

  assign sh_in = i_ops.imm_form ? {{(`CPU_XLEN-8){1'b0}}, i_ops.imm8} : i_ops.op_b;

  barrel_shifter shifter_inst (
    .i_value    (sh_in),
    .i_amount   (i_ops.shift_amt),
    .i_type     (i_ops.shift_type),
    .i_imm_form (i_ops.imm_form),
    .i_carry_in (flags_q.c),
    .o_value    (sh_out),
    .o_carry    (sh_carry)
  );

  // subtraction as x + ~y + cin, so carry out is not-borrow
  always_comb begin
    add_x    = i_ops.op_a;
    add_y    = sh_out;
    add_cin  = 1'b0;
    is_arith = 1'b1;
    case (i_ops.opcode)
      OP_SUB, OP_CMP: begin
        add_y   = ~sh_out;
        add_cin = 1'b1;
      end
      OP_RSB: begin
        add_x   = sh_out;
        add_y   = ~i_ops.op_a;
        add_cin = 1'b1;
      end
      OP_ADD, OP_CMN: add_cin = 1'b0;
      OP_ADC: add_cin = flags_q.c;
      OP_SBC: begin
        add_y   = ~sh_out;
        add_cin = flags_q.c;
      end
      OP_RSC: begin
        add_x   = sh_out;
        add_y   = ~i_ops.op_a;
        add_cin = flags_q.c;
      end
      default: is_arith = 1'b0;
    endcase
  end

  assign sum   = {1'b0, add_x} + {1'b0, add_y} + {{`CPU_XLEN{1'b0}}, add_cin};
  assign add_v = (add_x[`CPU_XLEN-1] == add_y[`CPU_XLEN-1]) &&
                 (sum[`CPU_XLEN-1] != add_x[`CPU_XLEN-1]);

  always_comb begin
    case (i_ops.opcode)
      OP_AND, OP_TST: result = i_ops.op_a & sh_out;
      OP_EOR, OP_TEQ: result = i_ops.op_a ^ sh_out;
      OP_ORR: result = i_ops.op_a | sh_out;
      OP_MOV: result = sh_out;
      OP_BIC: result = i_ops.op_a & ~sh_out;
      OP_MVN: result = ~sh_out;
      default: result = sum[`CPU_XLEN-1:0];
    endcase
  end

  assign executes = i_ops.valid && i_ops.is_dp && cond_pass(i_ops.cond, flags_q);
  // TST, TEQ, CMP and CMN only set flags
  assign writes   = i_ops.opcode[3:2] != 2'b10;

  always_comb begin
    o_wb.valid = executes && writes;
    o_wb.rd    = i_ops.rd;
    o_wb.data  = result;
  end

  always_comb begin
    flags_d = flags_q;
    if (executes && i_ops.set_flags) begin
      flags_d.n = result[`CPU_XLEN-1];
      flags_d.z = (result == '0);
      flags_d.c = is_arith ? sum[`CPU_XLEN] : sh_carry;
      // logical ops keep V
      if (is_arith) begin
        flags_d.v = add_v;
      end
    end
  end

  always_ff @(posedge clk) begin
    flags_q          <= flags_d;
    retire_q.valid   <= i_ops.valid;
    retire_q.written <= o_wb.valid;
    retire_q.rd      <= i_ops.rd;
    retire_q.data    <= o_wb.valid ? result : '0;
    retire_q.flags   <= flags_d;
    if (i_reset) begin
      flags_q        <= '0;
      retire_q.valid <= 1'b0;
    end
  end

  assign o_retire = retire_q;
  assign o_flags  = flags_q;

endmodule

`default_nettype wire

//--- hw/operand_stage.sv
`timescale 1ns/1ps
`default_nettype none

`include "cpu_macros.svh"

module operand_stage import pipe_pkg::*; (
  input  logic      clk,
  input  logic      i_reset,
  input  decoded_t  i_dec,
  input  wb_t       i_wb,
  output operands_t o_ops
);

  logic [`CPU_XLEN-1:0] regs [`CPU_NREGS];
  logic [`CPU_XLEN-1:0] rn_val;
  logic [`CPU_XLEN-1:0] rm_val;
  logic                 hit_rn;
  logic                 hit_rm;
  operands_t            ops_d;
  operands_t            ops_q;

  // register file, written at the same edge execute commits
  always_ff @(posedge clk) begin
    if (i_reset) begin
      for (int i = 0; i < `CPU_NREGS; i++) begin
        regs[i] <= '0;
      end
    end else if (i_wb.valid) begin
      regs[i_wb.rd] <= i_wb.data;
    end
  end

  // execute is finishing the previous instruction this cycle
  assign hit_rn = i_wb.valid && (i_wb.rd == i_dec.rn);
  assign hit_rm = i_wb.valid && (i_wb.rd == i_dec.rm);

  assign rn_val = hit_rn ? i_wb.data : regs[i_dec.rn];
  assign rm_val = hit_rm ? i_wb.data : regs[i_dec.rm];

  always_comb begin
    ops_d.valid      = i_dec.valid;
    ops_d.is_dp      = i_dec.is_dp;
    ops_d.cond       = i_dec.cond;
    ops_d.opcode     = i_dec.opcode;
    ops_d.set_flags  = i_dec.set_flags;
    ops_d.rd         = i_dec.rd;
    ops_d.imm_form   = i_dec.imm_form;
    ops_d.shift_type = i_dec.shift_type;
    ops_d.shift_amt  = i_dec.shift_amt;
    ops_d.imm8       = i_dec.imm8;
    ops_d.op_a       = rn_val;
    ops_d.op_b       = rm_val;
  end

  always_ff @(posedge clk) begin
    ops_q <= ops_d;
    if (i_reset) begin
      ops_q.valid <= 1'b0;
    end
  end

  assign o_ops = ops_q;

endmodule

`default_nettype wire

//--- hw/decode_stage.sv
`timescale 1ns/1ps
`default_nettype none

`include "cpu_macros.svh"

module decode_stage import isa_pkg::*, pipe_pkg::*; (
  input  logic     clk,
  input  logic     i_reset,
  input  logic     i_valid,
  input  instr_t   i_instr,
  output decoded_t o_dec
);

  decoded_t dec_d;
  decoded_t dec_q;
  logic     psr_xfer;
  logic     reg_shift;

  // opcodes 8..11 with S clear are PSR transfer, not compares
  assign psr_xfer  = (i_instr.opcode[3:2] == 2'b10) && !i_instr.set_flags;
  // bit 4 set in register form is a register shift or multiply space
  assign reg_shift = !i_instr.imm && i_instr.op2.shifted.reg_shift;

  always_comb begin
    dec_d.valid     = i_valid;
    dec_d.is_dp     = (i_instr.op_class == 2'b00) && !psr_xfer && !reg_shift;
    dec_d.cond      = i_instr.cond;
    dec_d.opcode    = i_instr.opcode;
    dec_d.set_flags = i_instr.set_flags;
    dec_d.rn        = i_instr.rn;
    dec_d.rd        = i_instr.rd;
    if (i_instr.imm) begin
      // immediate is a right rotate by twice the field
      dec_d.rm         = '0;
      dec_d.imm_form   = 1'b1;
      dec_d.shift_type = SH_ROR;
      dec_d.shift_amt  = {i_instr.op2.rotated.rotate, 1'b0};
      dec_d.imm8       = i_instr.op2.rotated.imm8;
    end else begin
      dec_d.rm         = i_instr.op2.shifted.rm;
      dec_d.imm_form   = 1'b0;
      dec_d.shift_type = i_instr.op2.shifted.shift_type;
      dec_d.shift_amt  = i_instr.op2.shifted.shift_amt;
      dec_d.imm8       = '0;
    end
  end

  always_ff @(posedge clk) begin
    dec_q <= dec_d;
    if (i_reset) begin
      dec_q.valid <= 1'b0;
    end
  end

  assign o_dec = dec_q;

endmodule

`default_nettype wire

//--- hw/barrel_shifter.sv
`timescale 1ns/1ps
`default_nettype none

`include "cpu_macros.svh"

module barrel_shifter import isa_pkg::*; (
  input  logic [`CPU_XLEN-1:0]       i_value,
  input  logic [`CPU_SHAMT_BITS-1:0] i_amount,
  input  shift_e                     i_type,
  input  logic                       i_imm_form,
  input  logic                       i_carry_in,
  output logic [`CPU_XLEN-1:0]       o_value,
  output logic                       o_carry
);

  logic                   zero_amt;
  logic [2*`CPU_XLEN-1:0] rot_wide;
  logic [`CPU_XLEN-1:0]   rot_val;
  logic [`CPU_XLEN:0]     lsl_wide;
  logic [`CPU_XLEN:0]     lsr_wide;
  logic [`CPU_XLEN:0]     asr_wide;

  assign zero_amt = (i_amount == '0);

  // doubled word gives rotate right
  assign rot_wide = {i_value, i_value} >> i_amount;
  assign rot_val  = rot_wide[`CPU_XLEN-1:0];

  // extra bit catches the last bit shifted out
  assign lsl_wide = {1'b0, i_value} << i_amount;
  assign lsr_wide = {i_value, 1'b0} >> i_amount;
  assign asr_wide = $signed({i_value, 1'b0}) >>> i_amount;

  always_comb begin
    o_value = i_value;
    o_carry = i_carry_in;
    if (i_imm_form) begin
      o_value = rot_val;
      o_carry = zero_amt ? i_carry_in : rot_val[`CPU_XLEN-1];
    end else begin
      case (i_type)
        SH_LSL: begin
          // LSL #0 passes value and carry
          if (!zero_amt) begin
            o_value = lsl_wide[`CPU_XLEN-1:0];
            o_carry = lsl_wide[`CPU_XLEN];
          end
        end
        SH_LSR: begin
          // amount 0 encodes LSR #32
          o_value = zero_amt ? '0 : lsr_wide[`CPU_XLEN:1];
          o_carry = zero_amt ? i_value[`CPU_XLEN-1] : lsr_wide[0];
        end
        SH_ASR: begin
          o_value = zero_amt ? {`CPU_XLEN{i_value[`CPU_XLEN-1]}} : asr_wide[`CPU_XLEN:1];
          o_carry = zero_amt ? i_value[`CPU_XLEN-1] : asr_wide[0];
        end
        default: begin
          // ROR #0 is RRX
          o_value = zero_amt ? {i_carry_in, i_value[`CPU_XLEN-1:1]} : rot_val;
          o_carry = zero_amt ? i_value[0] : rot_val[`CPU_XLEN-1];
        end
      endcase
    end
  end

endmodule

`default_nettype wire

//--- hw/pipe_pkg.sv
`default_nettype none

`include "cpu_macros.svh"

package pipe_pkg;
  import isa_pkg::*;

  // decode to operand stage
  typedef struct packed {
    logic                       valid;
    logic                       is_dp;
    cond_e                      cond;
    alu_op_e                    opcode;
    logic                       set_flags;
    logic [`CPU_REG_BITS-1:0]   rn;
    logic [`CPU_REG_BITS-1:0]   rd;
    logic [`CPU_REG_BITS-1:0]   rm;
    logic                       imm_form;
    shift_e                     shift_type;
    logic [`CPU_SHAMT_BITS-1:0] shift_amt;
    logic [7:0]                 imm8;
  } decoded_t;

  // operand to execute stage, op_b not yet shifted
  typedef struct packed {
    logic                       valid;
    logic                       is_dp;
    cond_e                      cond;
    alu_op_e                    opcode;
    logic                       set_flags;
    logic [`CPU_REG_BITS-1:0]   rd;
    logic                       imm_form;
    shift_e                     shift_type;
    logic [`CPU_SHAMT_BITS-1:0] shift_amt;
    logic [7:0]                 imm8;
    logic [`CPU_XLEN-1:0]       op_a;
    logic [`CPU_XLEN-1:0]       op_b;
  } operands_t;

  // register write, also the bypass source
  typedef struct packed {
    logic                     valid;
    logic [`CPU_REG_BITS-1:0] rd;
    logic [`CPU_XLEN-1:0]     data;
  } wb_t;

  typedef struct packed {
    logic                     valid;
    logic                     written;
    logic [`CPU_REG_BITS-1:0] rd;
    logic [`CPU_XLEN-1:0]     data;
    flags_t                   flags;
  } retire_t;

endpackage

`default_nettype wire

//--- hw/isa_pkg.sv
`default_nettype none

`include "cpu_macros.svh"

package isa_pkg;

  // data-processing opcodes, bits 24:21
  typedef enum logic [3:0] {
    OP_AND = 4'd0,
    OP_EOR = 4'd1,
    OP_SUB = 4'd2,
    OP_RSB = 4'd3,
    OP_ADD = 4'd4,
    OP_ADC = 4'd5,
    OP_SBC = 4'd6,
    OP_RSC = 4'd7,
    OP_TST = 4'd8,
    OP_TEQ = 4'd9,
    OP_CMP = 4'd10,
    OP_CMN = 4'd11,
    OP_ORR = 4'd12,
    OP_MOV = 4'd13,
    OP_BIC = 4'd14,
    OP_MVN = 4'd15
  } alu_op_e;

  // condition field, bits 31:28
  typedef enum logic [3:0] {
    COND_EQ, COND_NE, COND_CS, COND_CC,
    COND_MI, COND_PL, COND_VS, COND_VC,
    COND_HI, COND_LS, COND_GE, COND_LT,
    COND_GT, COND_LE, COND_AL, COND_NV
  } cond_e;

  typedef enum logic [1:0] {
    SH_LSL = 2'd0,
    SH_LSR = 2'd1,
    SH_ASR = 2'd2,
    SH_ROR = 2'd3
  } shift_e;

  typedef struct packed {
    logic n;
    logic z;
    logic c;
    logic v;
  } flags_t;

  // operand 2 when I is clear
  typedef struct packed {
    logic [`CPU_SHAMT_BITS-1:0] shift_amt;
    shift_e                     shift_type;
    logic                       reg_shift;
    logic [`CPU_REG_BITS-1:0]   rm;
  } dp_reg_t;

  // operand 2 when I is set
  typedef struct packed {
    logic [3:0] rotate;
    logic [7:0] imm8;
  } dp_imm_t;

  typedef union packed {
    dp_reg_t shifted;
    dp_imm_t rotated;
  } operand2_u;

  typedef struct packed {
    cond_e                    cond;
    logic [1:0]               op_class;
    logic                     imm;
    alu_op_e                  opcode;
    logic                     set_flags;
    logic [`CPU_REG_BITS-1:0] rn;
    logic [`CPU_REG_BITS-1:0] rd;
    operand2_u                op2;
  } instr_t;

endpackage

`default_nettype wire

//--- include/cpu_macros.svh
`ifndef CPU_MACROS_SVH
`define CPU_MACROS_SVH

// data word width
`define CPU_XLEN 32

// general purpose registers, all sixteen usable
`define CPU_NREGS 16

// register index width
`define CPU_REG_BITS 4

// rising edges from the sampling edge to the retire output
`define CPU_LATENCY 3

// room for a wider core later
`define CPU_SHAMT_BITS 5

`endif
